// File: hw/lce_cmd_macros.svh
/*
  Width and count settings of the data-cache command handler.
  Derived widths follow from the base values and assume powers of two.
*/
`ifndef LCE_CMD_MACROS_SVH
`define LCE_CMD_MACROS_SVH

`define LCE_PADDR_W      22
`define LCE_SETS         16
`define LCE_WAYS         4
`define LCE_DATA_W       64
`define LCE_NUM_CCE      2
`define LCE_NUM_LCE      4

`define LCE_INDEX_W      ($clog2(`LCE_SETS))
`define LCE_WAY_W        ($clog2(`LCE_WAYS))
`define LCE_BLOCK_OFF_W  ($clog2(`LCE_DATA_W))
`define LCE_TAG_W        (`LCE_PADDR_W - `LCE_INDEX_W - `LCE_BLOCK_OFF_W)
`define LCE_CCE_ID_W     ($clog2(`LCE_NUM_CCE))
`define LCE_LCE_ID_W     ($clog2(`LCE_NUM_LCE))

`endif

// File: hw/lce_msg_pkg.sv
/*
  Coherence network message types between the directory and the agent.
  Command opcode 2 is left free, the transfer command is not supported.
*/
`include "lce_cmd_macros.svh"

package lce_msg_pkg;

  // commands from the directory
  typedef enum logic [2:0] {
    e_lce_cmd_sync           = 3'd0,
    e_lce_cmd_set_clear      = 3'd1,
    e_lce_cmd_writeback      = 3'd3,
    e_lce_cmd_set_tag        = 3'd4,
    e_lce_cmd_set_tag_wakeup = 3'd5,
    e_lce_cmd_invalidate_tag = 3'd6
  } lce_cmd_msg_e;

  // plain responses
  typedef enum logic [0:0] {
    e_lce_cce_sync_ack = 1'b0,
    e_lce_cce_inv_ack  = 1'b1
  } lce_resp_msg_e;

  // responses that may carry a line
  typedef enum logic [0:0] {
    e_lce_resp_wb      = 1'b0,
    e_lce_resp_null_wb = 1'b1
  } lce_data_resp_msg_e;

  // coherence state as stored in the tag memory
  typedef logic [1:0] coh_state_t;

  typedef logic [`LCE_CCE_ID_W-1:0] cce_id_t;

endpackage

// File: hw/dcache_mem_pkg.sv
/*
  Cache memory packet types and the command handler state.
*/
`include "lce_cmd_macros.svh"

package dcache_mem_pkg;

  typedef enum logic [1:0] {
    e_dcache_lce_tag_mem_set_clear  = 2'd0,
    e_dcache_lce_tag_mem_set_tag    = 2'd1,
    e_dcache_lce_tag_mem_invalidate = 2'd2
  } tag_mem_op_e;

  typedef enum logic [1:0] {
    e_dcache_lce_stat_mem_set_clear   = 2'd0,
    e_dcache_lce_stat_mem_read        = 2'd1,
    e_dcache_lce_stat_mem_clear_dirty = 2'd2
  } stat_mem_op_e;

  typedef enum logic [2:0] {
    e_lce_cmd_state_sync,
    e_lce_cmd_state_ready,
    e_lce_cmd_state_wb,
    e_lce_cmd_state_wb_dirty,
    e_lce_cmd_state_wb_not_dirty
  } lce_cmd_state_e;

  typedef logic [`LCE_INDEX_W-1:0] cache_index_t;
  typedef logic [`LCE_WAY_W-1:0]   way_id_t;
  typedef logic [`LCE_TAG_W-1:0]   cache_tag_t;
  typedef logic [`LCE_DATA_W-1:0]  cache_line_t;

endpackage

// File: hw/mem_pkt_if.sv
/*
  Tag, status and data memory requests of the command handler.
  Each request is valid/yumi; a yumi accepts the request in its cycle.
*/
`timescale 1ns/10ps

interface mem_pkt_if;
  import lce_msg_pkg::*;
  import dcache_mem_pkg::*;

  logic         tag_v;
  tag_mem_op_e  tag_op;
  cache_index_t tag_index;
  way_id_t      tag_way;
  cache_tag_t   tag_tag;
  coh_state_t   tag_state;
  logic         tag_yumi;

  logic         stat_v;
  stat_mem_op_e stat_op;
  cache_index_t stat_index;
  way_id_t      stat_way;
  logic         stat_yumi;

  // data memory reads only
  logic         data_v;
  cache_index_t data_index;
  way_id_t      data_way;
  logic         data_yumi;

  modport requester (
    output tag_v, tag_op, tag_index, tag_way, tag_tag, tag_state,
    output stat_v, stat_op, stat_index, stat_way,
    output data_v, data_index, data_way,
    input  tag_yumi, stat_yumi, data_yumi
  );

  modport memory (
    input  tag_v, tag_op, tag_index, tag_way, tag_tag, tag_state,
    input  stat_v, stat_op, stat_index, stat_way,
    input  data_v, data_index, data_way,
    output tag_yumi, stat_yumi, data_yumi
  );

endinterface

// File: hw/lce_cmd_fsm.sv
/*
  Command decode and sequencing for one agent. Commands must hold stable
  until consumed. Only sync and set-clear are handled before sync is done;
  any other opcode waits unconsumed in the state where it is not decoded.
*/
`timescale 1ns/10ps
`include "lce_cmd_macros.svh"

module lce_cmd_fsm (
  input  logic                              clk_i,
  input  logic                              reset_i,
  mem_pkt_if.requester                      mem,

  input  logic                              lce_cmd_v_i,
  input  lce_msg_pkg::lce_cmd_msg_e         lce_cmd_msg_i,
  input  lce_msg_pkg::cce_id_t              lce_cmd_src_i,
  input  logic [`LCE_PADDR_W-1:0]           lce_cmd_addr_i,
  input  dcache_mem_pkg::way_id_t           lce_cmd_way_i,
  input  lce_msg_pkg::coh_state_t           lce_cmd_state_i,
  output logic                              lce_cmd_yumi_o,

  output logic                              lce_resp_v_o,
  output lce_msg_pkg::lce_resp_msg_e        lce_resp_msg_o,
  output lce_msg_pkg::cce_id_t              lce_resp_dst_o,
  output logic [`LCE_PADDR_W-1:0]           lce_resp_addr_o,
  input  logic                              lce_resp_yumi_i,

  output logic                              lce_data_resp_v_o,
  output lce_msg_pkg::lce_data_resp_msg_e   lce_data_resp_msg_o,
  output lce_msg_pkg::cce_id_t              lce_data_resp_dst_o,
  output logic [`LCE_PADDR_W-1:0]           lce_data_resp_addr_o,
  input  logic                              lce_data_resp_ready_i,

  input  logic [`LCE_WAYS-1:0]              dirty_i,
  output logic                              sync_done_o,
  output logic                              tag_set_o,
  output logic                              tag_set_wakeup_o,

  output logic                              sync_ack_o,
  input  logic                              last_cce_i,

  output logic                              wb_start_o,
  input  logic                              data_read_i,
  input  logic                              dirty_cleared_i,
  output logic                              resp_done_o,
  input  logic                              inv_pending_i,
  output logic                              tag_accepted_o
);
  import lce_msg_pkg::*;
  import dcache_mem_pkg::*;

  lce_cmd_state_e state_r;
  lce_cmd_state_e state_n;
  cache_index_t   cmd_index;
  cache_tag_t     cmd_tag;
  logic           data_resp_done;

  assign cmd_index = lce_cmd_addr_i[`LCE_BLOCK_OFF_W +: `LCE_INDEX_W];
  assign cmd_tag   = lce_cmd_addr_i[`LCE_BLOCK_OFF_W + `LCE_INDEX_W +: `LCE_TAG_W];

  // packet fields follow the held command, only valids and opcodes vary
  assign mem.tag_index  = cmd_index;
  assign mem.tag_way    = lce_cmd_way_i;
  assign mem.tag_tag    = cmd_tag;
  assign mem.tag_state  = lce_cmd_state_i;
  assign mem.stat_index = cmd_index;
  assign mem.stat_way   = lce_cmd_way_i;
  assign mem.data_index = cmd_index;
  assign mem.data_way   = lce_cmd_way_i;

  assign lce_resp_dst_o       = lce_cmd_src_i;
  assign lce_resp_addr_o      = lce_cmd_addr_i;
  assign lce_data_resp_dst_o  = lce_cmd_src_i;
  assign lce_data_resp_addr_o = lce_cmd_addr_i;
  assign lce_data_resp_msg_o  = (state_r == e_lce_cmd_state_wb_not_dirty) ?
                                e_lce_resp_null_wb : e_lce_resp_wb;

  assign data_resp_done = lce_data_resp_v_o & lce_data_resp_ready_i;
  assign resp_done_o    = data_resp_done | (lce_resp_v_o & lce_resp_yumi_i);
  assign wb_start_o     = (state_r == e_lce_cmd_state_wb_dirty);
  assign sync_done_o    = (state_r != e_lce_cmd_state_sync);

  always_comb begin
    state_n           = state_r;
    lce_cmd_yumi_o    = 1'b0;
    lce_resp_v_o      = 1'b0;
    lce_resp_msg_o    = e_lce_cce_sync_ack;
    lce_data_resp_v_o = 1'b0;
    tag_set_o         = 1'b0;
    tag_set_wakeup_o  = 1'b0;
    sync_ack_o        = 1'b0;
    tag_accepted_o    = 1'b0;
    mem.tag_v         = 1'b0;
    mem.tag_op        = e_dcache_lce_tag_mem_set_tag;
    mem.stat_v        = 1'b0;
    mem.stat_op       = e_dcache_lce_stat_mem_read;
    mem.data_v        = 1'b0;

    case (state_r)
      e_lce_cmd_state_sync: begin
        case (lce_cmd_msg_i)
          e_lce_cmd_sync: begin
            lce_resp_v_o   = lce_cmd_v_i;
            lce_cmd_yumi_o = lce_resp_yumi_i;
            sync_ack_o     = lce_resp_yumi_i;
            // leave on the ack to the last directory
            if (last_cce_i & lce_resp_yumi_i) begin
              state_n = e_lce_cmd_state_ready;
            end
          end
          e_lce_cmd_set_clear: begin
            mem.tag_v      = lce_cmd_v_i;
            mem.tag_op     = e_dcache_lce_tag_mem_set_clear;
            mem.stat_v     = lce_cmd_v_i;
            mem.stat_op    = e_dcache_lce_stat_mem_set_clear;
            lce_cmd_yumi_o = mem.tag_yumi & mem.stat_yumi;
          end
          default: ;
        endcase
      end

      e_lce_cmd_state_ready: begin
        case (lce_cmd_msg_i)
          e_lce_cmd_set_tag: begin
            mem.tag_v      = lce_cmd_v_i;
            lce_cmd_yumi_o = mem.tag_yumi;
            tag_set_o      = mem.tag_yumi;
          end
          e_lce_cmd_set_tag_wakeup: begin
            mem.tag_v        = lce_cmd_v_i;
            lce_cmd_yumi_o   = mem.tag_yumi;
            tag_set_wakeup_o = mem.tag_yumi;
          end
          e_lce_cmd_invalidate_tag: begin
            // tag first, then hold the ack until taken
            mem.tag_v      = lce_cmd_v_i & ~inv_pending_i;
            mem.tag_op     = e_dcache_lce_tag_mem_invalidate;
            tag_accepted_o = mem.tag_yumi;
            lce_resp_v_o   = inv_pending_i | mem.tag_yumi;
            lce_resp_msg_o = e_lce_cce_inv_ack;
            lce_cmd_yumi_o = lce_resp_yumi_i;
          end
          e_lce_cmd_writeback: begin
            mem.stat_v = lce_cmd_v_i;
            if (mem.stat_yumi) begin
              state_n = e_lce_cmd_state_wb;
            end
          end
          default: ;
        endcase
      end

      // status read data is on dirty_i now
      e_lce_cmd_state_wb: begin
        state_n = dirty_i[lce_cmd_way_i] ? e_lce_cmd_state_wb_dirty :
                  e_lce_cmd_state_wb_not_dirty;
      end

      e_lce_cmd_state_wb_dirty: begin
        mem.data_v        = ~data_read_i;
        // dirty bit is cleared once the line is safely read
        mem.stat_v        = ~dirty_cleared_i & (data_read_i | mem.data_yumi);
        mem.stat_op       = e_dcache_lce_stat_mem_clear_dirty;
        lce_data_resp_v_o = data_read_i & (dirty_cleared_i | mem.stat_yumi);
        lce_cmd_yumi_o    = data_resp_done;
        if (data_resp_done) begin
          state_n = e_lce_cmd_state_ready;
        end
      end

      e_lce_cmd_state_wb_not_dirty: begin
        lce_data_resp_v_o = 1'b1;
        lce_cmd_yumi_o    = data_resp_done;
        if (data_resp_done) begin
          state_n = e_lce_cmd_state_ready;
        end
      end

      default: state_n = e_lce_cmd_state_sync;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_lce_cmd_state_sync;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// File: hw/sync_ack_counter.sv
/*
  Counts sync-acks accepted by the directories during the sync phase.
  The count saturates once every directory has been acknowledged.
*/
`timescale 1ns/10ps
`include "lce_cmd_macros.svh"

module sync_ack_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic sync_ack_i,
  output logic last_cce_o
);

  localparam int CNT_W = $clog2(`LCE_NUM_CCE + 1);

  logic [CNT_W-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (sync_ack_i && (count_r != CNT_W'(`LCE_NUM_CCE))) begin
      count_r <= count_r + 1'b1;
    end
  end

  // next accepted ack completes the sync phase
  assign last_cce_o = (count_r == CNT_W'(`LCE_NUM_CCE - 1));

endmodule

// File: hw/wb_data_buffer.sv
/*
  Writeback progress flags and the buffered line.
  Memory read data is expected one cycle after the read is accepted.
  All flags drop when the pending response completes.
*/
`timescale 1ns/10ps

module wb_data_buffer (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        data_yumi_i,
  input  logic                        stat_yumi_i,
  input  logic                        wb_start_i,
  input  logic                        resp_done_i,
  input  logic                        tag_accepted_i,
  input  dcache_mem_pkg::cache_line_t data_mem_data_i,
  output logic                        data_read_o,
  output logic                        dirty_cleared_o,
  output logic                        inv_pending_o,
  output dcache_mem_pkg::cache_line_t line_o
);
  import dcache_mem_pkg::*;

  logic        data_read_r;
  logic        dirty_cleared_r;
  logic        inv_pending_r;
  // memory data arrives this cycle
  logic        capture_r;
  cache_line_t line_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || resp_done_i) begin
      data_read_r     <= 1'b0;
      dirty_cleared_r <= 1'b0;
      inv_pending_r   <= 1'b0;
    end else begin
      if (wb_start_i && data_yumi_i) begin
        data_read_r <= 1'b1;
      end
      if (wb_start_i && stat_yumi_i) begin
        dirty_cleared_r <= 1'b1;
      end
      if (tag_accepted_i) begin
        inv_pending_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      capture_r <= 1'b0;
    end else begin
      capture_r <= wb_start_i & data_yumi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_r) begin
      line_r <= data_mem_data_i;
    end
  end

  assign data_read_o     = data_read_r;
  assign dirty_cleared_o = dirty_cleared_r;
  assign inv_pending_o   = inv_pending_r;
  // bypass so the response can leave in the capture cycle
  assign line_o          = capture_r ? data_mem_data_i : line_r;

endmodule

// File: hw/lce_cmd_top.sv
/*
  Data-cache command handler for a single agent, one command at a time.
  Memory requests are valid/yumi, the data response is valid/ready.
*/
`timescale 1ns/10ps
`include "lce_cmd_macros.svh"

module lce_cmd_top (
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic                              lce_cmd_v_i,
  input  lce_msg_pkg::lce_cmd_msg_e         lce_cmd_msg_i,
  input  lce_msg_pkg::cce_id_t              lce_cmd_src_i,
  input  logic [`LCE_PADDR_W-1:0]           lce_cmd_addr_i,
  input  dcache_mem_pkg::way_id_t           lce_cmd_way_i,
  input  lce_msg_pkg::coh_state_t           lce_cmd_state_i,
  output logic                              lce_cmd_yumi_o,

  output logic                              lce_resp_v_o,
  output lce_msg_pkg::lce_resp_msg_e        lce_resp_msg_o,
  output lce_msg_pkg::cce_id_t              lce_resp_dst_o,
  output logic [`LCE_PADDR_W-1:0]           lce_resp_addr_o,
  input  logic                              lce_resp_yumi_i,

  output logic                              lce_data_resp_v_o,
  output lce_msg_pkg::lce_data_resp_msg_e   lce_data_resp_msg_o,
  output lce_msg_pkg::cce_id_t              lce_data_resp_dst_o,
  output logic [`LCE_PADDR_W-1:0]           lce_data_resp_addr_o,
  output dcache_mem_pkg::cache_line_t       lce_data_resp_data_o,
  input  logic                              lce_data_resp_ready_i,

  output logic                              tag_mem_v_o,
  output dcache_mem_pkg::tag_mem_op_e       tag_mem_op_o,
  output dcache_mem_pkg::cache_index_t      tag_mem_index_o,
  output dcache_mem_pkg::way_id_t           tag_mem_way_o,
  output dcache_mem_pkg::cache_tag_t        tag_mem_tag_o,
  output lce_msg_pkg::coh_state_t           tag_mem_state_o,
  input  logic                              tag_mem_yumi_i,

  output logic                              stat_mem_v_o,
  output dcache_mem_pkg::stat_mem_op_e      stat_mem_op_o,
  output dcache_mem_pkg::cache_index_t      stat_mem_index_o,
  output dcache_mem_pkg::way_id_t           stat_mem_way_o,
  input  logic                              stat_mem_yumi_i,
  input  logic [`LCE_WAYS-1:0]              dirty_i,

  output logic                              data_mem_v_o,
  output dcache_mem_pkg::cache_index_t      data_mem_index_o,
  output dcache_mem_pkg::way_id_t           data_mem_way_o,
  input  logic                              data_mem_yumi_i,
  input  dcache_mem_pkg::cache_line_t       data_mem_data_i,

  output logic                              sync_done_o,
  output logic                              tag_set_o,
  output logic                              tag_set_wakeup_o
);

  logic sync_ack;
  logic last_cce;
  logic wb_start;
  logic data_read;
  logic dirty_cleared;
  logic resp_done;
  logic inv_pending;
  logic tag_accepted;

  mem_pkt_if mem ();

  assign tag_mem_v_o      = mem.tag_v;
  assign tag_mem_op_o     = mem.tag_op;
  assign tag_mem_index_o  = mem.tag_index;
  assign tag_mem_way_o    = mem.tag_way;
  assign tag_mem_tag_o    = mem.tag_tag;
  assign tag_mem_state_o  = mem.tag_state;
  assign mem.tag_yumi     = tag_mem_yumi_i;

  assign stat_mem_v_o     = mem.stat_v;
  assign stat_mem_op_o    = mem.stat_op;
  assign stat_mem_index_o = mem.stat_index;
  assign stat_mem_way_o   = mem.stat_way;
  assign mem.stat_yumi    = stat_mem_yumi_i;

  assign data_mem_v_o     = mem.data_v;
  assign data_mem_index_o = mem.data_index;
  assign data_mem_way_o   = mem.data_way;
  assign mem.data_yumi    = data_mem_yumi_i;

  lce_cmd_fsm u_lce_cmd_fsm (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .mem                   (mem.requester),
    .lce_cmd_v_i           (lce_cmd_v_i),
    .lce_cmd_msg_i         (lce_cmd_msg_i),
    .lce_cmd_src_i         (lce_cmd_src_i),
    .lce_cmd_addr_i        (lce_cmd_addr_i),
    .lce_cmd_way_i         (lce_cmd_way_i),
    .lce_cmd_state_i       (lce_cmd_state_i),
    .lce_cmd_yumi_o        (lce_cmd_yumi_o),
    .lce_resp_v_o          (lce_resp_v_o),
    .lce_resp_msg_o        (lce_resp_msg_o),
    .lce_resp_dst_o        (lce_resp_dst_o),
    .lce_resp_addr_o       (lce_resp_addr_o),
    .lce_resp_yumi_i       (lce_resp_yumi_i),
    .lce_data_resp_v_o     (lce_data_resp_v_o),
    .lce_data_resp_msg_o   (lce_data_resp_msg_o),
    .lce_data_resp_dst_o   (lce_data_resp_dst_o),
    .lce_data_resp_addr_o  (lce_data_resp_addr_o),
    .lce_data_resp_ready_i (lce_data_resp_ready_i),
    .dirty_i               (dirty_i),
    .sync_done_o           (sync_done_o),
    .tag_set_o             (tag_set_o),
    .tag_set_wakeup_o      (tag_set_wakeup_o),
    .sync_ack_o            (sync_ack),
    .last_cce_i            (last_cce),
    .wb_start_o            (wb_start),
    .data_read_i           (data_read),
    .dirty_cleared_i       (dirty_cleared),
    .resp_done_o           (resp_done),
    .inv_pending_i         (inv_pending),
    .tag_accepted_o        (tag_accepted)
  );

  sync_ack_counter u_sync_ack_counter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sync_ack_i (sync_ack),
    .last_cce_o (last_cce)
  );

  wb_data_buffer u_wb_data_buffer (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .data_yumi_i     (mem.data_yumi),
    .stat_yumi_i     (mem.stat_yumi),
    .wb_start_i      (wb_start),
    .resp_done_i     (resp_done),
    .tag_accepted_i  (tag_accepted),
    .data_mem_data_i (data_mem_data_i),
    .data_read_o     (data_read),
    .dirty_cleared_o (dirty_cleared),
    .inv_pending_o   (inv_pending),
    .line_o          (lce_data_resp_data_o)
  );

endmodule

// File: verif/lce_cmd_assertions.sv
/*
  Handshake checks on the command handler ports.
  Bound to every instance of the top level.
*/
`timescale 1ns/10ps

module lce_cmd_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic lce_cmd_v_i,
  input logic lce_cmd_yumi_o,
  input logic tag_mem_v_o,
  input logic stat_mem_v_o,
  input logic data_mem_v_o,
  input logic lce_resp_v_o,
  input logic lce_data_resp_v_o,
  input logic lce_data_resp_ready_i
);

  // a command is consumed only while it is offered
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_yumi_o |-> lce_cmd_v_i)
    else $error("command yumi asserted without its valid");

  a_quiet_after_reset: assert property (@(posedge clk_i)
    ($past(reset_i) && !reset_i) |-> !(tag_mem_v_o || stat_mem_v_o || data_mem_v_o ||
    lce_resp_v_o || lce_data_resp_v_o))
    else $error("valid high in the first cycle after reset");

  a_data_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_data_resp_v_o && !lce_data_resp_ready_i) |=> lce_data_resp_v_o)
    else $error("data response valid dropped before ready");

endmodule

bind lce_cmd_top lce_cmd_assertions u_lce_cmd_assertions (
  .clk_i                 (clk_i),
  .reset_i               (reset_i),
  .lce_cmd_v_i           (lce_cmd_v_i),
  .lce_cmd_yumi_o        (lce_cmd_yumi_o),
  .tag_mem_v_o           (tag_mem_v_o),
  .stat_mem_v_o          (stat_mem_v_o),
  .data_mem_v_o          (data_mem_v_o),
  .lce_resp_v_o          (lce_resp_v_o),
  .lce_data_resp_v_o     (lce_data_resp_v_o),
  .lce_data_resp_ready_i (lce_data_resp_ready_i)
);

// File: verif/lce_cmd_tb.sv
/*
  Golden-file testbench for the command handler. The memory model accepts
  requests at random (fixed seed) and returns read data one cycle later.
  Up to 32 golden lines are read.
*/
`timescale 1ns/10ps
`include "lce_cmd_macros.svh"

module lce_cmd_tb;
  import lce_msg_pkg::*;
  import dcache_mem_pkg::*;

  localparam int MAX_CMDS = 32;

  logic clk_i, reset_i;
  logic lce_cmd_v_i, lce_cmd_yumi_o;
  lce_cmd_msg_e lce_cmd_msg_i;
  cce_id_t lce_cmd_src_i;
  logic [`LCE_PADDR_W-1:0] lce_cmd_addr_i;
  way_id_t lce_cmd_way_i;
  coh_state_t lce_cmd_state_i;
  logic lce_resp_v_o, lce_resp_yumi_i;
  lce_resp_msg_e lce_resp_msg_o;
  cce_id_t lce_resp_dst_o, lce_data_resp_dst_o;
  logic [`LCE_PADDR_W-1:0] lce_resp_addr_o, lce_data_resp_addr_o;
  logic lce_data_resp_v_o, lce_data_resp_ready_i;
  lce_data_resp_msg_e lce_data_resp_msg_o;
  cache_line_t lce_data_resp_data_o, data_mem_data_i, gold_line;
  logic tag_mem_v_o, tag_mem_yumi_i, stat_mem_v_o, stat_mem_yumi_i;
  tag_mem_op_e tag_mem_op_o;
  stat_mem_op_e stat_mem_op_o;
  cache_index_t tag_mem_index_o, stat_mem_index_o, data_mem_index_o;
  way_id_t tag_mem_way_o, stat_mem_way_o, data_mem_way_o;
  cache_tag_t tag_mem_tag_o;
  coh_state_t tag_mem_state_o;
  logic [`LCE_WAYS-1:0] dirty_i;
  logic data_mem_v_o, data_mem_yumi_i;
  logic sync_done_o, tag_set_o, tag_set_wakeup_o;

  // random accept enables, one per handshake
  logic tag_en, stat_en, data_en, resp_en;
  logic [31:0] lfsr;
  int mismatches, failures, cycles, cycle_limit, n_cmds, acks_total;

  logic [2:0] g_msg[MAX_CMDS];
  logic [`LCE_CCE_ID_W-1:0] g_src[MAX_CMDS];
  logic [`LCE_PADDR_W-1:0] g_addr[MAX_CMDS];
  logic [`LCE_WAY_W-1:0] g_way[MAX_CMDS];
  logic [1:0] g_state[MAX_CMDS];
  logic [`LCE_WAYS-1:0] g_dirty[MAX_CMDS];
  logic [`LCE_DATA_W-1:0] g_line[MAX_CMDS], g_data[MAX_CMDS];
  logic [2:0] g_kind[MAX_CMDS];
  logic [1:0] g_pulse[MAX_CMDS];
  logic g_done[MAX_CMDS];

  lce_cmd_top u_lce_cmd_top (.*);

  assign tag_mem_yumi_i  = tag_en & tag_mem_v_o;
  assign stat_mem_yumi_i = stat_en & stat_mem_v_o;
  assign data_mem_yumi_i = data_en & data_mem_v_o;
  assign lce_resp_yumi_i = resp_en & lce_resp_v_o;

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  always @(posedge clk_i) begin
    logic [31:0] s;
    s = lfsr;
    s = lfsr_step(s);
    tag_en <= s[0];
    s = lfsr_step(s);
    stat_en <= s[0];
    s = lfsr_step(s);
    data_en <= s[0];
    s = lfsr_step(s);
    resp_en <= s[0];
    s = lfsr_step(s);
    lce_data_resp_ready_i <= s[0];
    lfsr <= s;
    // read data comes back the cycle after the read is taken
    data_mem_data_i <= (data_mem_v_o & data_mem_yumi_i) ? gold_line : '0;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, a command was never consumed", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic check_resp(input lce_resp_msg_e msg, input cce_id_t dst,
                            input logic [`LCE_PADDR_W-1:0] addr);
    if (lce_resp_msg_o !== msg || lce_resp_dst_o !== dst || lce_resp_addr_o !== addr) begin
      mismatches++;
      $display("Mismatch at %0t lce_resp msg/dst/addr: expected %0d/%0d/%h, got %0d/%0d/%h",
               $time, msg, dst, addr, lce_resp_msg_o, lce_resp_dst_o, lce_resp_addr_o);
    end
  endtask

  task automatic check_data_resp(input lce_data_resp_msg_e msg, input cce_id_t dst,
                                 input logic [`LCE_PADDR_W-1:0] addr,
                                 input cache_line_t data, input logic with_data);
    if (lce_data_resp_msg_o !== msg || lce_data_resp_dst_o !== dst ||
        lce_data_resp_addr_o !== addr ||
        (with_data && lce_data_resp_data_o !== data)) begin
      mismatches++;
      $display("Mismatch at %0t lce_data_resp msg/dst/addr/data: expected %0d/%0d/%h/%h,",
               $time, msg, dst, addr, data, " got %0d/%0d/%h/%h", lce_data_resp_msg_o,
               lce_data_resp_dst_o, lce_data_resp_addr_o, lce_data_resp_data_o);
    end
  endtask

  task automatic check_tag_pkt(input tag_mem_op_e op, input cache_index_t index,
                               input way_id_t way, input cache_tag_t tag,
                               input coh_state_t st);
    // set clear covers every way of the set
    if (tag_mem_op_o !== op || tag_mem_index_o !== index || tag_mem_tag_o !== tag ||
        (op != e_dcache_lce_tag_mem_set_clear && tag_mem_way_o !== way) ||
        (op == e_dcache_lce_tag_mem_set_tag && tag_mem_state_o !== st)) begin
      mismatches++;
      $display("Mismatch at %0t tag_mem op/index/way/tag/state: expected %0d/%h/%0d/%h/%0d,",
               $time, op, index, way, tag, st, " got %0d/%h/%0d/%h/%0d", tag_mem_op_o,
               tag_mem_index_o, tag_mem_way_o, tag_mem_tag_o, tag_mem_state_o);
    end
  endtask

  task automatic check_stat_pkt(input stat_mem_op_e op, input cache_index_t index,
                                input way_id_t way);
    if (stat_mem_op_o !== op || stat_mem_index_o !== index ||
        (op != e_dcache_lce_stat_mem_set_clear && stat_mem_way_o !== way)) begin
      mismatches++;
      $display("Mismatch at %0t stat_mem op/index/way: expected %0d/%h/%0d, got %0d/%h/%0d",
               $time, op, index, way, stat_mem_op_o, stat_mem_index_o, stat_mem_way_o);
    end
  endtask

  task automatic check_data_req(input cache_index_t index, input way_id_t way);
    if (data_mem_index_o !== index || data_mem_way_o !== way) begin
      mismatches++;
      $display("Mismatch at %0t data_mem index/way: expected %h/%0d, got %h/%0d",
               $time, index, way, data_mem_index_o, data_mem_way_o);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic count_check(input string what, input int exp, input int got);
    if (exp != got) begin
      failures++;
      $display("wrong number of %s at %0t: expected %0d, saw %0d", what, $time, exp, got);
    end
  endtask

  task automatic read_golden();
    int fd;
    string text;
    fd = $fopen("verif/lce_cmd_golden.txt", "r");
    n_cmds = 0;
    if (fd == 0) begin
      failures++;
      $display("golden file could not be opened");
    end else begin
      while (!$feof(fd) && n_cmds < MAX_CMDS) begin
        text = "";
        void'($fgets(text, fd));
        if (text.len() > 1 && text[0] != "#") begin
          if ($sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h", g_msg[n_cmds],
                      g_src[n_cmds], g_addr[n_cmds], g_way[n_cmds], g_state[n_cmds],
                      g_dirty[n_cmds], g_line[n_cmds], g_kind[n_cmds], g_data[n_cmds],
                      g_pulse[n_cmds], g_done[n_cmds]) == 11) begin
            n_cmds++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_cmd(input int i);
    tag_mem_op_e op;
    stat_mem_op_e stat_op;
    cache_index_t index;
    int tag_pkts, stat_pkts, resps, data_resps, clears, reads;
    bit tag_exp;
    tag_pkts = 0;
    stat_pkts = 0;
    resps = 0;
    data_resps = 0;
    clears = 0;
    reads = 0;
    tag_exp = (g_msg[i] != 3'd0 && g_msg[i] != 3'd3);
    op = (g_msg[i] == 3'd1) ? e_dcache_lce_tag_mem_set_clear :
         (g_msg[i] == 3'd6) ? e_dcache_lce_tag_mem_invalidate : e_dcache_lce_tag_mem_set_tag;
    // set index sits just above the line offset
    index = cache_index_t'(g_addr[i] >> `LCE_BLOCK_OFF_W);
    @(posedge clk_i);
    lce_cmd_v_i     <= 1'b1;
    lce_cmd_msg_i   <= lce_cmd_msg_e'(g_msg[i]);
    lce_cmd_src_i   <= g_src[i];
    lce_cmd_addr_i  <= g_addr[i];
    lce_cmd_way_i   <= g_way[i];
    lce_cmd_state_i <= g_state[i];
    dirty_i         <= g_dirty[i];
    gold_line       <= g_line[i];
    forever begin
      @(negedge clk_i);
      if (sync_done_o && acks_total < `LCE_NUM_CCE) begin
        failures++;
        $display("sync done raised at %0t before every directory acked", $time);
      end
      if (tag_mem_v_o && tag_mem_yumi_i) begin
        tag_pkts++;
        check_tag_pkt(op, index, g_way[i], g_addr[i][`LCE_PADDR_W-1 -: `LCE_TAG_W],
                      g_state[i]);
      end
      if (stat_mem_v_o && stat_mem_yumi_i) begin
        // a writeback reads the status first, a dirty line then clears it
        stat_op = (g_msg[i] == 3'd1) ? e_dcache_lce_stat_mem_set_clear :
                  (stat_pkts == 0) ? e_dcache_lce_stat_mem_read :
                  e_dcache_lce_stat_mem_clear_dirty;
        check_stat_pkt(stat_op, index, g_way[i]);
        stat_pkts++;
        if (stat_mem_op_o == e_dcache_lce_stat_mem_clear_dirty)
          clears++;
      end
      if (data_mem_v_o && data_mem_yumi_i) begin
        reads++;
        check_data_req(index, g_way[i]);
      end
      if (lce_resp_v_o && lce_resp_yumi_i) begin
        resps++;
        acks_total += (g_kind[i] == 3'd1);
        check_resp((g_kind[i] == 3'd2) ? e_lce_cce_inv_ack : e_lce_cce_sync_ack,
                   g_src[i], g_addr[i]);
      end
      if (lce_data_resp_v_o && lce_data_resp_ready_i) begin
        data_resps++;
        check_data_resp((g_kind[i] == 3'd4) ? e_lce_resp_null_wb : e_lce_resp_wb,
                        g_src[i], g_addr[i], g_data[i], g_kind[i] == 3'd3);
      end
      if (lce_cmd_yumi_o) begin
        check_bit("tag_set_o", g_pulse[i] == 2'd1, tag_set_o);
        check_bit("tag_set_wakeup_o", g_pulse[i] == 2'd2, tag_set_wakeup_o);
        break;
      end
      // status pulses belong to the consuming cycle only
      check_bit("tag_set_o", 1'b0, tag_set_o);
      check_bit("tag_set_wakeup_o", 1'b0, tag_set_wakeup_o);
    end
    @(posedge clk_i);
    lce_cmd_v_i <= 1'b0;
    @(negedge clk_i);
    check_bit("sync_done_o", g_done[i], sync_done_o);
    // set clear repeats its tag packet while the status memory stalls
    if (g_msg[i] == 3'd1 && tag_pkts == 0)
      count_check("tag packets", 1, 0);
    if (g_msg[i] != 3'd1)
      count_check("tag packets", tag_exp ? 1 : 0, tag_pkts);
    count_check("responses", (g_kind[i] == 3'd1 || g_kind[i] == 3'd2) ? 1 : 0, resps);
    count_check("data responses", (g_kind[i] >= 3'd3) ? 1 : 0, data_resps);
    count_check("clear_dirty packets", (g_kind[i] == 3'd3) ? 1 : 0, clears);
    count_check("data reads", (g_kind[i] == 3'd3) ? 1 : 0, reads);
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    lfsr = 32'h5b94f20b;
    {tag_en, stat_en, data_en, resp_en, lce_data_resp_ready_i} = '0;
    lce_cmd_v_i = 1'b0;
    lce_cmd_msg_i = e_lce_cmd_sync;
    lce_cmd_src_i = '0;
    lce_cmd_addr_i = '0;
    lce_cmd_way_i = '0;
    lce_cmd_state_i = '0;
    dirty_i = '0;
    data_mem_data_i = '0;
    gold_line = '0;
    mismatches = 0;
    failures = 0;
    cycles = 0;
    acks_total = 0;
    cycle_limit = 1000;
    read_golden();
    cycle_limit = n_cmds * 64;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < n_cmds; i++) begin
      run_cmd(i);
    end
    if (n_cmds == 0) begin
      failures++;
      $display("no commands were read from the golden file");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: lce_cmd_top.f
+incdir+hw
hw/lce_msg_pkg.sv
hw/dcache_mem_pkg.sv
hw/mem_pkt_if.sv
hw/lce_cmd_fsm.sv
hw/sync_ack_counter.sv
hw/wb_data_buffer.sv
hw/lce_cmd_top.sv
verif/lce_cmd_assertions.sv
verif/lce_cmd_tb.sv

// File: verif/lce_cmd_golden.txt
# msg src addr way state dirty line | kind(0 none 1 sync_ack 2 inv_ack 3 wb 4 null_wb)
# expected data, pulse(0 none 1 tag_set 2 wakeup), sync_done after the command; all hex
1 0 000040 0 0 0 0000000000000000 0 0000000000000000 0 0
1 0 000080 0 0 0 0000000000000000 0 0000000000000000 0 0
0 0 000000 0 0 0 0000000000000000 1 0000000000000000 0 0
0 1 000000 0 0 0 0000000000000000 1 0000000000000000 0 1
4 1 2a5c40 2 3 0 0000000000000000 0 0000000000000000 1 1
5 0 1f3880 1 2 0 0000000000000000 0 0000000000000000 2 1
6 1 2a5c40 2 0 0 0000000000000000 2 0000000000000000 0 1
3 0 133340 3 0 8 0123456789abcdef 3 0123456789abcdef 0 1
3 1 0a0a00 0 0 e 5555aaaa5555aaaa 4 0000000000000000 0 1
3 1 3fffc0 1 0 2 deadbeefcafef00d 3 deadbeefcafef00d 0 1
4 0 3fffc0 1 1 0 0000000000000000 0 0000000000000000 1 1
6 0 3fffc0 1 0 0 0000000000000000 2 0000000000000000 0 1
5 1 000440 3 1 f 0000000000000000 0 0000000000000000 2 1
3 0 000440 3 0 f 0f1e2d3c4b5a6978 3 0f1e2d3c4b5a6978 0 1
